//--- icache_fill_pkg.sv
// Shared transaction id type and line geometry for the I-cache refill return path; import it
package icache_fill_pkg;

	// ==========================================================================
	// Line geometry
	// ==========================================================================

	// One bus beat carries a quarter of a cache line
	localparam int BEAT_W = 128;
	localparam int BEATS_PER_LINE = 4;
	localparam int LINE_W = BEAT_W * BEATS_PER_LINE;

	// Number of refills that may be outstanding at the same time
	localparam int SLOTS = 4;

	// Byte offset bits within a 64-byte line; these are cleared to form a tag
	localparam int LINE_OFS_W = 6;

	// Width of the beat number, found just below the line boundary in the address
	localparam int BEAT_IDX_W = $clog2(BEATS_PER_LINE);

	// ==========================================================================
	// Transaction id
	// ==========================================================================

	// The fetch unit builds an id from the assembly slot and a sequence number
	// so that a slot can be reused before an older request's tag is retired
	typedef struct packed {
		logic [1:0] slot;
		logic [1:0] sub;
	} tran_id_split_t;

	// The tag table indexes by the whole id, while the assembler only needs
	// the slot field, so both views of the same four bits are kept here
	typedef union packed {
		logic [3:0] raw;
		tran_id_split_t split;
	} tran_id_u;

endpackage

//--- refill_tag_table.sv
// Virtual line address table for outstanding I-cache misses, written on issue, read by id
`timescale 1ns/1ns

module refill_tag_table import icache_fill_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input tran_id_u req_tid,
	input logic [ADDR_W-1:0] req_vadr,
	input tran_id_u lookup_tid,
	output logic [ADDR_W-1:0] lookup_vtag
);

	// One entry per possible transaction id
	localparam int ENTRIES = 16;

	logic [ADDR_W-1:0] vtag [ENTRIES];

	// ==========================================================================
	// Write side
	// ==========================================================================

	// The fetch unit records the miss address when it issues the request.
	// Only the line-aligned part is kept, since the cache tags whole lines
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ENTRIES; i++) begin
				vtag[i] <= '0;
			end
		end else if (req_valid) begin
			vtag[req_tid.raw] <= {req_vadr[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
		end
	end

	// ==========================================================================
	// Read side
	// ==========================================================================

	// Unregistered read so the fill writer can capture the tag in the same
	// cycle as the completed line
	assign lookup_vtag = vtag[lookup_tid.raw];

endmodule

//--- line_assembler.sv
// Collects returned refill beats per slot and presents each finished 512-bit line for one cycle
`timescale 1ns/1ns

module line_assembler import icache_fill_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input logic clk,
	input logic rst,
	input logic ack,
	input tran_id_u ack_tid,
	input logic [ADDR_W-1:0] ack_adr,
	input logic [BEAT_W-1:0] ack_dat,
	output logic line_done,
	output tran_id_u done_tid,
	output logic [ADDR_W-1:0] done_ptag,
	output logic [LINE_W-1:0] done_data
);

	localparam int SLOT_W = $clog2(SLOTS);

	// Per-slot state. The mask is control, the rest is payload
	logic [BEATS_PER_LINE-1:0] valid [SLOTS];
	tran_id_u last_tid [SLOTS];
	logic [ADDR_W-1:0] ptag [SLOTS];
	logic [LINE_W-1:0] line_buf [SLOTS];

	// Decoded fields of the incoming beat
	logic [SLOT_W-1:0] ack_slot;
	logic [BEAT_IDX_W-1:0] ack_beat;
	logic [ADDR_W-1:0] ack_ptag;

	// Completion detect
	logic [SLOTS-1:0] slot_full;
	logic any_full;
	logic [SLOT_W-1:0] done_sel;

	// ==========================================================================
	// Beat decode
	// ==========================================================================

	// The slot comes from the id, the beat number from address bits 5:4
	assign ack_slot = ack_tid.split.slot;
	assign ack_beat = ack_adr[LINE_OFS_W-1 -: BEAT_IDX_W];
	assign ack_ptag = {ack_adr[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

	// ==========================================================================
	// Completion detect
	// ==========================================================================

	// Only one beat arrives per cycle and a full mask is cleared on the next
	// edge, so at most one slot is ever full at a time. The loop still picks
	// the lowest full slot to keep the select well defined
	always_comb begin
		any_full = 1'b0;
		done_sel = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			slot_full[s] = &valid[s];
			if (slot_full[s]) begin
				any_full = 1'b1;
				done_sel = SLOT_W'(s);
			end
		end
	end

	// ==========================================================================
	// Control state
	// ==========================================================================

	// A full slot is emptied on the edge that raises line_done. A beat for
	// the same slot on that edge sets its own bit afterwards, so it opens a
	// fresh mask instead of being lost. A repeated beat just sets a bit that
	// is already set and does not move completion forward
	always_ff @(posedge clk) begin
		if (rst) begin
			line_done <= 1'b0;
			for (int s = 0; s < SLOTS; s++) begin
				valid[s] <= '0;
			end
		end else begin
			line_done <= any_full;
			for (int s = 0; s < SLOTS; s++) begin
				if (slot_full[s]) begin
					valid[s] <= '0;
				end
			end
			if (ack) begin
				valid[ack_slot][ack_beat] <= 1'b1;
			end
		end
	end

	// ==========================================================================
	// Payload capture
	// ==========================================================================

	// Beat k lands in bits 128k+127..128k. The id and physical tag follow
	// the most recent beat, so done_tid is the id of the final beat
	always_ff @(posedge clk) begin
		if (ack) begin
			line_buf[ack_slot][ack_beat*BEAT_W +: BEAT_W] <= ack_dat;
			last_tid[ack_slot] <= ack_tid;
			ptag[ack_slot] <= ack_ptag;
		end
		// Output copy is taken from the old slot contents, before any
		// beat written on this same edge
		if (any_full) begin
			done_tid <= last_tid[done_sel];
			done_ptag <= ptag[done_sel];
			done_data <= line_buf[done_sel];
		end
	end

endmodule

//--- fill_writer.sv
// Turns a completed refill line into one registered cache write with its tags and a victim way
`timescale 1ns/1ns

module fill_writer import icache_fill_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int LOG_WAYS = 2
) (
	input logic clk,
	input logic rst,
	input logic line_done,
	input tran_id_u done_tid,
	input logic [ADDR_W-1:0] done_ptag,
	input logic [LINE_W-1:0] done_data,
	output tran_id_u lookup_tid,
	input logic [ADDR_W-1:0] lookup_vtag,
	output logic wr_ic,
	output logic [LOG_WAYS-1:0] way,
	output logic [ADDR_W-1:0] line_vtag,
	output logic [ADDR_W-1:0] line_ptag,
	output logic [LINE_W-1:0] line_data
);

	localparam int LFSR_W = 17;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 17'h00001;

	logic [LFSR_W-1:0] lfsr;

	// ==========================================================================
	// Victim selection
	// ==========================================================================

	// Free-running Fibonacci LFSR with taps at bits 16 and 13. It steps
	// every cycle whether or not a write is pending, so the way picked
	// depends on when the line finishes
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[LFSR_W-2:0], lfsr[16] ^ lfsr[13]};
		end
	end

	// ==========================================================================
	// Tag lookup
	// ==========================================================================

	// The virtual tag belongs to the id of the line being presented now;
	// the table answers in the same cycle
	assign lookup_tid = done_tid;

	// ==========================================================================
	// Cache write
	// ==========================================================================

	// wr_ic is a single-cycle strobe. The line fields hold their value
	// until the next write so the cache may sample them at leisure
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ic <= 1'b0;
			way <= '0;
			line_vtag <= '0;
			line_ptag <= '0;
			line_data <= '0;
		end else begin
			wr_ic <= line_done;
			if (line_done) begin
				way <= lfsr[LOG_WAYS-1:0];
				line_vtag <= lookup_vtag;
				line_ptag <= done_ptag;
				line_data <= done_data;
			end
		end
	end

endmodule

//--- icache_fill_top.sv
// Top of the I-cache refill return path; connects tag table, line assembler and fill writer
`timescale 1ns/1ns

module icache_fill_top import icache_fill_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int LOG_WAYS = 2
) (
	input logic clk,
	input logic rst,
	// Miss record from the fetch unit
	input logic req_valid,
	input tran_id_u req_tid,
	input logic [ADDR_W-1:0] req_vadr,
	// Returned beats from the memory bus
	input logic ack,
	input tran_id_u ack_tid,
	input logic [ADDR_W-1:0] ack_adr,
	input logic [BEAT_W-1:0] ack_dat,
	// Cache write
	output logic wr_ic,
	output logic [LOG_WAYS-1:0] way,
	output logic [ADDR_W-1:0] line_vtag,
	output logic [ADDR_W-1:0] line_ptag,
	output logic [LINE_W-1:0] line_data
);

	// Assembler to writer
	logic line_done;
	tran_id_u done_tid;
	logic [ADDR_W-1:0] done_ptag;
	logic [LINE_W-1:0] done_data;

	// Writer to table and back
	tran_id_u lookup_tid;
	logic [ADDR_W-1:0] lookup_vtag;

	// ==========================================================================
	// Instances
	// ==========================================================================

	refill_tag_table #(.ADDR_W(ADDR_W)) refill_tag_table_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_tid(req_tid),
		.req_vadr(req_vadr),
		.lookup_tid(lookup_tid),
		.lookup_vtag(lookup_vtag)
	);

	line_assembler #(.ADDR_W(ADDR_W)) line_assembler_i (
		.clk(clk),
		.rst(rst),
		.ack(ack),
		.ack_tid(ack_tid),
		.ack_adr(ack_adr),
		.ack_dat(ack_dat),
		.line_done(line_done),
		.done_tid(done_tid),
		.done_ptag(done_ptag),
		.done_data(done_data)
	);

	// Two cycles from the last ack to wr_ic: one in the assembler, one here
	fill_writer #(.ADDR_W(ADDR_W), .LOG_WAYS(LOG_WAYS)) fill_writer_i (
		.clk(clk),
		.rst(rst),
		.line_done(line_done),
		.done_tid(done_tid),
		.done_ptag(done_ptag),
		.done_data(done_data),
		.lookup_tid(lookup_tid),
		.lookup_vtag(lookup_vtag),
		.wr_ic(wr_ic),
		.way(way),
		.line_vtag(line_vtag),
		.line_ptag(line_ptag),
		.line_data(line_data)
	);

endmodule

//--- icache_fill_props.sv
// Concurrent properties of the refill write strobe, bound into the refill top level
`timescale 1ns/1ns

module icache_fill_props (
	input logic clk,
	input logic rst,
	input logic line_done,
	input logic wr_ic
);

	// Number of property failures seen so far
	int fail_count = 0;

	// The write strobe is low right after any reset cycle
	a_quiet_after_rst: assert property (@(posedge clk) rst |=> !wr_ic)
		else begin
			fail_count++;
			$error("wr_ic high in the cycle after rst");
		end

	// Every completed line turns into a write on the next cycle
	a_done_to_write: assert property (@(posedge clk) disable iff (rst) line_done |=> wr_ic)
		else begin
			fail_count++;
			$error("line_done not followed by wr_ic");
		end

	// No write without a completed line the cycle before
	a_write_has_done: assert property (@(posedge clk) disable iff (rst)
			wr_ic |-> $past(line_done))
		else begin
			fail_count++;
			$error("wr_ic without line_done in the previous cycle");
		end

endmodule

bind icache_fill_top icache_fill_props props_i (
	.clk(clk),
	.rst(rst),
	.line_done(line_done),
	.wr_ic(wr_ic)
);

//--- tb_icache_fill.sv
// Random-fill testbench for the I-cache refill return path; run it as the simulation top
`timescale 1ns/1ns

module tb_icache_fill import icache_fill_pkg::*; ();

	localparam int CLK_HALF = 4;
	localparam logic [31:0] SEED = 32'h73aa1ce1;
	localparam int DRAIN_LIMIT = 20;

	// One expected cache write and the edge that must raise wr_ic
	typedef struct {
		int edge_no;
		tran_id_u tid;
		logic [31:0] ptag;
		logic [LINE_W-1:0] data;
	} write_t;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	tran_id_u req_tid;
	logic [31:0] req_vadr;
	logic ack;
	tran_id_u ack_tid;
	logic [31:0] ack_adr;
	logic [BEAT_W-1:0] ack_dat;
	logic wr_ic;
	logic [1:0] way;
	logic [31:0] line_vtag;
	logic [31:0] line_ptag;
	logic [LINE_W-1:0] line_data;

	// ==========================================================================
	// Reference model state
	// ==========================================================================

	logic [31:0] lcg_state = SEED;
	logic [16:0] m_lfsr = 17'h00001;
	logic [3:0] m_mask [SLOTS];
	logic [LINE_W-1:0] m_buf [SLOTS];
	logic [31:0] m_vtag [16];
	write_t exp_q [$];
	int cyc = 0;

	icache_fill_top icache_fill_top_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_tid(req_tid),
		.req_vadr(req_vadr),
		.ack(ack),
		.ack_tid(ack_tid),
		.ack_adr(ack_adr),
		.ack_dat(ack_dat),
		.wr_ic(wr_ic),
		.way(way),
		.line_vtag(line_vtag),
		.line_ptag(line_ptag),
		.line_data(line_data)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [LINE_W-1:0] got,
			input logic [LINE_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ==========================================================================
	// Clock step with model update and output check
	// ==========================================================================

	// The model sees the inputs sampled on this edge, then the outputs are
	// compared 1 ns later, which is also when the next inputs are driven
	task automatic tick();
		logic [16:0] pre_lfsr;
		logic [31:0] head_vtag;
		logic [1:0] slot;
		logic [1:0] beat;
		write_t w;
		@(posedge clk);
		cyc++;
		pre_lfsr = m_lfsr;
		// The writer reads the tag table in the cycle before the write edge,
		// so a miss recorded on this edge is not yet visible to it
		head_vtag = '0;
		if (exp_q.size() > 0) begin
			head_vtag = m_vtag[exp_q[0].tid.raw];
		end
		if (rst) begin
			m_lfsr = 17'h00001;
			for (int s = 0; s < SLOTS; s++) begin
				m_mask[s] = '0;
			end
			for (int i = 0; i < 16; i++) begin
				m_vtag[i] = '0;
			end
		end else begin
			m_lfsr = {m_lfsr[15:0], m_lfsr[16] ^ m_lfsr[13]};
			if (req_valid) begin
				m_vtag[req_tid.raw] = {req_vadr[31:6], 6'b0};
			end
			if (ack) begin
				slot = ack_tid.split.slot;
				beat = ack_adr[5:4];
				m_buf[slot][beat*BEAT_W +: BEAT_W] = ack_dat;
				m_mask[slot][beat] = 1'b1;
				// A full line is written two edges after its last beat
				if (&m_mask[slot]) begin
					w.edge_no = cyc + 2;
					w.tid = ack_tid;
					w.ptag = {ack_adr[31:6], 6'b0};
					w.data = m_buf[slot];
					exp_q.push_back(w);
					m_mask[slot] = '0;
				end
			end
		end
		#1;
		if (exp_q.size() > 0 && exp_q[0].edge_no == cyc) begin
			w = exp_q.pop_front();
			check_value("wr_ic", LINE_W'(wr_ic), LINE_W'(1'b1));
			// Victim way is the LFSR value held just before the write edge
			check_value("way", LINE_W'(way), LINE_W'(pre_lfsr[1:0]));
			check_value("line_vtag", LINE_W'(line_vtag), LINE_W'(head_vtag));
			check_value("line_ptag", LINE_W'(line_ptag), LINE_W'(w.ptag));
			check_value("line_data", line_data, w.data);
		end else begin
			check_value("wr_ic", LINE_W'(wr_ic), '0);
		end
	endtask

	// ==========================================================================
	// Stimulus helpers
	// ==========================================================================

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			tick();
		end
	endtask

	task automatic issue_miss(input tran_id_u tid, input logic [31:0] vadr);
		req_valid = 1'b1;
		req_tid = tid;
		req_vadr = vadr;
		tick();
		req_valid = 1'b0;
	endtask

	// Low address nibble is noise; only bits 5:4 pick the beat
	task automatic send_beat(input tran_id_u tid, input logic [31:0] padr, input logic [1:0] beat);
		logic [31:0] r;
		r = rand32();
		ack = 1'b1;
		ack_tid = tid;
		ack_adr = {padr[31:6], beat, r[3:0]};
		ack_dat = {rand32(), rand32(), rand32(), rand32()};
		tick();
		ack = 1'b0;
	endtask

	// Random permutation of beats 0..3, two bits per entry
	function automatic logic [7:0] beat_order();
		logic [7:0] ord;
		logic [1:0] tmp;
		int j;
		ord = 8'b11_10_01_00;
		for (int i = 3; i > 0; i--) begin
			j = int'(rand32() % (i + 1));
			tmp = ord[i*2 +: 2];
			ord[i*2 +: 2] = ord[j*2 +: 2];
			ord[j*2 +: 2] = tmp;
		end
		return ord;
	endfunction

	task automatic fill_line(input tran_id_u tid, input logic [31:0] padr);
		logic [7:0] ord;
		ord = beat_order();
		for (int i = 0; i < 4; i++) begin
			send_beat(tid, padr, ord[i*2 +: 2]);
			idle(int'(rand32() % 3));
		end
	endtask

	// Waits for every queued write, giving up after a bounded number of cycles
	task automatic wait_writes();
		int n;
		n = 0;
		while (exp_q.size() > 0) begin
			if (n >= DRAIN_LIMIT) begin
				$display("timeout while waiting for an expected cache write");
				$display("test failed");
				$fatal(1, "timeout");
			end else begin
				tick();
				n++;
			end
		end
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		tran_id_u tid_a;
		tran_id_u tid_b;
		tran_id_u ti [SLOTS];
		logic [31:0] pa [SLOTS];
		logic [7:0] ord [SLOTS];
		int pos [SLOTS];
		int s;
		rst = 1'b1;
		req_valid = 1'b0;
		req_tid = '0;
		req_vadr = '0;
		ack = 1'b0;
		ack_tid = '0;
		ack_adr = '0;
		ack_dat = '0;
		idle(3);
		rst = 1'b0;

		// Line outputs come out of reset cleared
		check_value("way", LINE_W'(way), '0);
		check_value("line_vtag", LINE_W'(line_vtag), '0);
		check_value("line_ptag", LINE_W'(line_ptag), '0);
		check_value("line_data", line_data, '0);
		idle(4);

		// Three distinct beats and a repeat must not write; the fourth does
		tid_a.raw = 4'h4;
		issue_miss(tid_a, 32'h0001_2345);
		send_beat(tid_a, 32'h8000_1000, 2'd0);
		send_beat(tid_a, 32'h8000_1000, 2'd2);
		send_beat(tid_a, 32'h8000_1000, 2'd1);
		send_beat(tid_a, 32'h8000_1000, 2'd2);
		idle(12);
		send_beat(tid_a, 32'h8000_1000, 2'd3);
		wait_writes();

		// Back-to-back single fills with random id and beat order
		repeat (30) begin
			tid_a.raw = 4'(rand32());
			issue_miss(tid_a, rand32());
			fill_line(tid_a, rand32());
		end
		wait_writes();

		// Same slot, different sub, filled newest first
		tid_a.raw = 4'b1000;
		tid_b.raw = 4'b1011;
		issue_miss(tid_a, rand32());
		issue_miss(tid_b, rand32());
		fill_line(tid_b, rand32());
		fill_line(tid_a, rand32());
		wait_writes();

		// All four slots in flight with beats interleaved
		repeat (12) begin
			for (int k = 0; k < SLOTS; k++) begin
				ti[k].split.slot = 2'(k);
				ti[k].split.sub = 2'(rand32());
				pa[k] = rand32();
				ord[k] = beat_order();
				pos[k] = 0;
				issue_miss(ti[k], rand32());
			end
			for (int b = 0; b < 4 * SLOTS; b++) begin
				s = int'(rand32() % SLOTS);
				while (pos[s] == 4) begin
					s = (s + 1) % SLOTS;
				end
				send_beat(ti[s], pa[s], ord[s][pos[s]*2 +: 2]);
				pos[s]++;
				if (rand32() % 4 == 0) begin
					idle(1);
				end
			end
		end
		wait_writes();
		idle(4);

		if (icache_fill_top_i.props_i.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "property failures");
		end
	end

endmodule

//--- all.f
icache_fill_pkg.sv
refill_tag_table.sv
line_assembler.sv
fill_writer.sv
icache_fill_top.sv
icache_fill_props.sv
tb_icache_fill.sv

//--- run.sh
#!/bin/sh
# Builds the refill return path testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache_fill -f all.f -o sim_icache_fill

./obj_dir/sim_icache_fill > sim.log 2>&1 || true
cat sim.log

grep -qx "test passed" sim.log
